// ==== lsu_isa_pkg.sv ====
/* Data and register index types for the load/store unit
   Memory operation and access size encodings */

package lsu_isa_pkg;

// One byte enable per lane of a data word
localparam int WORD_BYTES = 4;

// Data widths seen by the core
typedef logic [31:0] word_t;
typedef logic [15:0] halfword_t;
typedef logic [7:0]  byte_t;

// Destination register index, x0 to x31
typedef logic [4:0]  reg_idx_t;

// Operation carried by a request
typedef enum logic [1:0] {
    MEM_OP_NOP   = 2'b00,
    MEM_OP_LOAD  = 2'b01,
    MEM_OP_STORE = 2'b10
} mem_op_e;

// Access width, 2'b11 is not used
typedef enum logic [1:0] {
    MEM_SIZE_BYTE     = 2'b00,
    MEM_SIZE_HALFWORD = 2'b01,
    MEM_SIZE_WORD     = 2'b10
} mem_size_e;

endpackage : lsu_isa_pkg

// ==== lsu_pipe_pkg.sv ====
/* Data RAM geometry and address widths
   Payload structs passed between the memory stages and writeback */

package lsu_pipe_pkg;

import lsu_isa_pkg::*;

// Data RAM size in words
localparam int RAM_WORDS     = 256;
// Word address width, derived from the RAM size
localparam int RAM_ADDR_W    = $clog2(RAM_WORDS);
// Low address bits that pick a byte inside a word
localparam int BYTE_OFFSET_W = $clog2(WORD_BYTES);

// Memory-1 to memory-2 payload
typedef struct packed {
    mem_op_e                  mem_op;
    mem_size_e                mem_size;
    // Sign extension of sub-word loads
    logic                     mem_signed;
    logic [BYTE_OFFSET_W-1:0] byte_offset;
    reg_idx_t                 rd_idx;
    // Access skipped the RAM
    logic                     misaligned;
} m1_to_m2_s;

// Response payload towards writeback
typedef struct packed {
    reg_idx_t rd_idx;
    // Only for a load that did not fault
    logic     rd_we;
    word_t    data;
    logic     fault;
} m2_to_w_s;

endpackage : lsu_pipe_pkg

// ==== lsu_stage_mem1.sv ====
/* Memory-1 stage with address generation, alignment check,
   store lane placement, byte enables and data RAM request */

module lsu_stage_mem1
    import lsu_isa_pkg::*;
    import lsu_pipe_pkg::*;
(
    input  logic                  req_valid,
    input  mem_op_e               req_op,
    input  mem_size_e             req_size,
    input  logic                  req_signed,
    input  word_t                 req_base,
    input  word_t                 req_offset,
    input  word_t                 req_wdata,
    input  reg_idx_t              req_rd,
    input  logic                  m1_ready,
    output logic                  m1_valid,
    output m1_to_m2_s             m1_to_m2,
    output logic                  ram_en,
    output logic                  ram_we,
    output logic [WORD_BYTES-1:0] ram_be,
    output logic [RAM_ADDR_W-1:0] ram_addr,
    output word_t                 ram_wdata
);

word_t                    addr;
logic [BYTE_OFFSET_W-1:0] offs;
logic                     misaligned;
logic                     is_access;
logic                     fire;
word_t                    lane_data;
logic [WORD_BYTES-1:0]    lane_be;

always_comb begin
    addr = req_base + req_offset;
    offs = addr[BYTE_OFFSET_W-1:0];
    // Store data is replicated over all lanes
    // Byte enables pick the live one
    case (req_size)
        MEM_SIZE_BYTE: begin
            misaligned = 1'b0;
            lane_data  = {4{req_wdata[7:0]}};
            lane_be    = 4'b0001 << offs;
        end
        MEM_SIZE_HALFWORD: begin
            misaligned = offs[0];
            lane_data  = {2{req_wdata[15:0]}};
            lane_be    = 4'b0011 << offs;
        end
        default: begin
            misaligned = offs != '0;
            lane_data  = req_wdata;
            lane_be    = '1;
        end
    endcase
end

// A NOP is consumed here and never reaches memory-2
assign is_access = (req_op == MEM_OP_LOAD) || (req_op == MEM_OP_STORE);
assign m1_valid  = req_valid && is_access;
assign fire      = m1_valid && m1_ready;

// RAM access only on a transfer and never for a misaligned request
assign ram_en    = fire && !misaligned;
assign ram_we    = ram_en && (req_op == MEM_OP_STORE);
assign ram_be    = ram_we ? lane_be : '0;
assign ram_addr  = addr[RAM_ADDR_W+BYTE_OFFSET_W-1:BYTE_OFFSET_W];
assign ram_wdata = lane_data;

always_comb begin
    m1_to_m2 = '{
        mem_op:      req_op,
        mem_size:    req_size,
        mem_signed:  req_signed,
        byte_offset: offs,
        rd_idx:      req_rd,
        misaligned:  misaligned
    };
end

// Enabled RAM access starts on a multiple of its size in bytes
always_comb begin
    if (ram_en) begin
        assert (((req_base + req_offset) & ((32'd1 << req_size) - 32'd1)
                 & 32'd3) == 32'd0)
        else $error("mem1: misaligned access enabled the RAM, addr %h", addr);
    end
end

endmodule : lsu_stage_mem1

// ==== lsu_pipe_reg.sv ====
/* One-entry valid/ready pipeline register, payload type given as a parameter */

module lsu_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     out_ready,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data
);

// Holds ready low through reset and the first cycle after it
logic run_en;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        run_en <= 1'b0;
    end else begin
        run_en <= 1'b1;
    end
end

// Empty, or draining in this same cycle
assign in_ready = run_en && (!out_valid || out_ready);

always_ff @(posedge clk) begin
    if (!rst_n) begin
        out_valid <= 1'b0;
    end else if (in_ready) begin
        out_valid <= in_valid;
    end
end

// Payload loads only on an accepted transfer
always_ff @(posedge clk) begin
    if (in_ready && in_valid) begin
        out_data <= in_data;
    end
end

// Stalled output keeps both valid and payload
assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
else $error("pipe_reg: output changed while stalled");

endmodule : lsu_pipe_reg

// ==== lsu_data_ram.sv ====
/* Synchronous single-port data RAM
   Per-byte write enables, registered read word */

module lsu_data_ram
    import lsu_isa_pkg::*;
    import lsu_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  en,
    input  logic                  we,
    input  logic [WORD_BYTES-1:0] be,
    input  logic [RAM_ADDR_W-1:0] addr,
    input  word_t                 wdata,
    output word_t                 rdata
);

// Word storage
word_t mem [RAM_WORDS];

// Byte lane writes
always_ff @(posedge clk) begin
    if (en && we) begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) begin
                mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end
end

// Read register
// Loads it on every enabled access, holds otherwise
always_ff @(posedge clk) begin
    if (en) begin
        if (we) begin
            // Stores return nothing
            rdata <= '0;
        end else begin
            rdata <= mem[addr];
        end
    end
end

endmodule : lsu_data_ram

// ==== lsu_stage_mem2.sv ====
/* Memory-2 stage: load lane selection, sign or zero extension,
   and assembly of the writeback response */

module lsu_stage_mem2
    import lsu_isa_pkg::*;
    import lsu_pipe_pkg::*;
(
    input  logic      in_valid,
    input  m1_to_m2_s m1_to_m2,
    input  word_t     ram_rdata,
    input  logic      out_ready,
    output logic      in_ready,
    output logic      out_valid,
    output m2_to_w_s  m2_to_w
);

halfword_t sel_hw;
byte_t     sel_byte;
logic      ext_hw;
logic      ext_byte;
word_t     load_data;
logic      is_load;
logic      load_ok;

// Lane pick, bit 1 for the halfword and bit 0 for the byte inside it
always_comb begin
    sel_hw   = m1_to_m2.byte_offset[1] ? ram_rdata[31:16] : ram_rdata[15:0];
    sel_byte = m1_to_m2.byte_offset[0] ? sel_hw[15:8] : sel_hw[7:0];
    // Fill bit, zero for unsigned loads
    ext_hw   = m1_to_m2.mem_signed & sel_hw[15];
    ext_byte = m1_to_m2.mem_signed & sel_byte[7];
    case (m1_to_m2.mem_size)
        MEM_SIZE_BYTE:     load_data = {{24{ext_byte}}, sel_byte};
        MEM_SIZE_HALFWORD: load_data = {{16{ext_hw}}, sel_hw};
        default:           load_data = ram_rdata;
    endcase
end

assign is_load = m1_to_m2.mem_op == MEM_OP_LOAD;
// Misaligned loads never read the RAM
assign load_ok = is_load && !m1_to_m2.misaligned;

// Combinational stage, handshake passes straight through
assign in_ready  = out_ready;
assign out_valid = in_valid;

// Stores and faults come back with zero data
always_comb begin
    m2_to_w = '{
        rd_idx: m1_to_m2.rd_idx,
        rd_we:  load_ok,
        data:   load_ok ? load_data : '0,
        fault:  m1_to_m2.misaligned
    };
end

// NOPs are dropped in memory-1 and must not show up here
always_comb begin
    if (in_valid) begin
        assert (m1_to_m2.mem_op != MEM_OP_NOP)
        else $error("mem2: NOP request arrived with valid set");
    end
end

endmodule : lsu_stage_mem2

// ==== lsu_top.sv ====
/* Load/store unit top: memory-1, memory-2, data RAM and two pipeline registers
   A request accepted at edge N transfers on writeback at edge N+2 without stalls */

module lsu_top
    import lsu_isa_pkg::*;
    import lsu_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  mem_op_e   req_op,
    input  mem_size_e req_size,
    input  logic      req_signed,
    input  word_t     req_base,
    input  word_t     req_offset,
    input  word_t     req_wdata,
    input  reg_idx_t  req_rd,
    input  logic      wb_ready,
    output logic      req_ready,
    output logic      wb_valid,
    output reg_idx_t  wb_rd,
    output logic      wb_we,
    output word_t     wb_data,
    output logic      wb_fault
);

// Memory-1 to first register
logic                  m1_valid;
logic                  m1_ready;
m1_to_m2_s             m1_payload;
// RAM request and read word
logic                  ram_en;
logic                  ram_we;
logic [WORD_BYTES-1:0] ram_be;
logic [RAM_ADDR_W-1:0] ram_addr;
word_t                 ram_wdata;
word_t                 ram_rdata;
// First register to memory-2
logic                  m2_valid;
logic                  m2_ready;
m1_to_m2_s             m2_payload;
// Memory-2 to response register
logic                  w_valid;
logic                  w_ready;
m2_to_w_s              w_payload;
m2_to_w_s              wb_payload;

// Request ready is the first register's ready
assign req_ready = m1_ready;

lsu_stage_mem1 u_mem1 (
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_size   (req_size),
    .req_signed (req_signed),
    .req_base   (req_base),
    .req_offset (req_offset),
    .req_wdata  (req_wdata),
    .req_rd     (req_rd),
    .m1_ready   (m1_ready),
    .m1_valid   (m1_valid),
    .m1_to_m2   (m1_payload),
    .ram_en     (ram_en),
    .ram_we     (ram_we),
    .ram_be     (ram_be),
    .ram_addr   (ram_addr),
    .ram_wdata  (ram_wdata)
);

lsu_data_ram u_ram (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_we),
    .be    (ram_be),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
);

// Aligned with the RAM read register
lsu_pipe_reg #(.payload_t(m1_to_m2_s)) u_m1_m2_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (m1_valid),
    .in_data   (m1_payload),
    .out_ready (m2_ready),
    .in_ready  (m1_ready),
    .out_valid (m2_valid),
    .out_data  (m2_payload)
);

lsu_stage_mem2 u_mem2 (
    .in_valid  (m2_valid),
    .m1_to_m2  (m2_payload),
    .ram_rdata (ram_rdata),
    .out_ready (w_ready),
    .in_ready  (m2_ready),
    .out_valid (w_valid),
    .m2_to_w   (w_payload)
);

// Response register on the writeback port
lsu_pipe_reg #(.payload_t(m2_to_w_s)) u_m2_w_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (w_valid),
    .in_data   (w_payload),
    .out_ready (wb_ready),
    .in_ready  (w_ready),
    .out_valid (wb_valid),
    .out_data  (wb_payload)
);

assign wb_rd    = wb_payload.rd_idx;
assign wb_we    = wb_payload.rd_we;
assign wb_data  = wb_payload.data;
assign wb_fault = wb_payload.fault;

endmodule : lsu_top

// ==== tb_lsu_top.sv ====
/* Testbench for the load/store unit top level
   Golden-file requests, random back-pressure, in-order response checks */

module tb_lsu_top
    import lsu_isa_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int          CLK_PERIOD   = 8;
localparam int          RESET_CYCLES = 5;
localparam int          MAX_VECTORS  = 64;
// Cycle limit for one pass over the golden file
localparam int          PASS_TIMEOUT = 2000;
localparam int          IDLE_CYCLES  = 4;
localparam logic [31:0] LFSR_SEED    = 32'h69d;
localparam string       GOLDEN_FILE  = "lsu_golden.txt";

logic      clk;
logic      rst_n;
logic      req_valid;
mem_op_e   req_op;
mem_size_e req_size;
logic      req_signed;
word_t     req_base;
word_t     req_offset;
word_t     req_wdata;
reg_idx_t  req_rd;
logic      wb_ready;
logic      req_ready;
logic      wb_valid;
reg_idx_t  wb_rd;
logic      wb_we;
word_t     wb_data;
logic      wb_fault;

// Requests and expected results from the golden file
logic [1:0]  vec_op     [MAX_VECTORS];
logic [1:0]  vec_size   [MAX_VECTORS];
logic        vec_signed [MAX_VECTORS];
word_t       vec_base   [MAX_VECTORS];
word_t       vec_offset [MAX_VECTORS];
word_t       vec_wdata  [MAX_VECTORS];
reg_idx_t    vec_rd     [MAX_VECTORS];
word_t       vec_data   [MAX_VECTORS];
logic        vec_fault  [MAX_VECTORS];
int          num_vectors;
int          error_count;
int          check_count;
logic [31:0] lfsr_state;

initial clk = 1'b0;
always #(CLK_PERIOD / 2) clk = ~clk;

lsu_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_size   (req_size),
    .req_signed (req_signed),
    .req_base   (req_base),
    .req_offset (req_offset),
    .req_wdata  (req_wdata),
    .req_rd     (req_rd),
    .wb_ready   (wb_ready),
    .req_ready  (req_ready),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_we      (wb_we),
    .wb_data    (wb_data),
    .wb_fault   (wb_fault)
);

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// One step per bit taken
function automatic logic random_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Fail %s: got %h, expected %h", name, actual, expected);
    end
endtask

task automatic load_golden();
    int          fd;
    int          count;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_size;
    logic [31:0] f_signed;
    logic [31:0] f_base;
    logic [31:0] f_offset;
    logic [31:0] f_wdata;
    logic [31:0] f_rd;
    logic [31:0] f_data;
    logic [31:0] f_fault;
    num_vectors = 0;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
        error_count++;
        $display("Could not open the golden file %s", GOLDEN_FILE);
        return;
    end
    while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Comment lines start with a hash
        if (line.len() == 0 || line[0] == "#") begin
            continue;
        end
        count = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_op, f_size, f_signed,
                        f_base, f_offset, f_wdata, f_rd, f_data, f_fault);
        if (count <= 0) begin
            continue;
        end
        if (count != 9 || num_vectors >= MAX_VECTORS) begin
            error_count++;
            $display("Golden file line could not be used: %s", line);
            continue;
        end
        vec_op[num_vectors]     = f_op[1:0];
        vec_size[num_vectors]   = f_size[1:0];
        vec_signed[num_vectors] = f_signed[0];
        vec_base[num_vectors]   = f_base;
        vec_offset[num_vectors] = f_offset;
        vec_wdata[num_vectors]  = f_wdata;
        vec_rd[num_vectors]     = f_rd[4:0];
        vec_data[num_vectors]   = f_data;
        vec_fault[num_vectors]  = f_fault[0];
        num_vectors++;
    end
    $fclose(fd);
endtask

task automatic drive_request(input int idx);
    req_valid  = 1'b1;
    req_op     = mem_op_e'(vec_op[idx]);
    req_size   = mem_size_e'(vec_size[idx]);
    req_signed = vec_signed[idx];
    req_base   = vec_base[idx];
    req_offset = vec_offset[idx];
    req_wdata  = vec_wdata[idx];
    req_rd     = vec_rd[idx];
endtask

task automatic apply_reset();
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    // Nothing accepted or presented while in reset
    check_value("req_ready (reset)", 32'(req_ready), 32'h0);
    check_value("wb_valid (reset)", 32'(wb_valid), 32'h0);
    rst_n = 1'b1;
endtask

// Register write only for a load without a fault
task automatic check_response(input int idx, input reg_idx_t rd, input logic we,
                              input word_t data, input logic fault);
    logic exp_we;
    exp_we = (vec_op[idx] == MEM_OP_LOAD) && !vec_fault[idx];
    check_value($sformatf("wb_rd (vector %0d)", idx), 32'(rd), 32'(vec_rd[idx]));
    check_value($sformatf("wb_we (vector %0d)", idx), 32'(we), 32'(exp_we));
    check_value($sformatf("wb_data (vector %0d)", idx), data, vec_data[idx]);
    check_value($sformatf("wb_fault (vector %0d)", idx), 32'(fault), 32'(vec_fault[idx]));
endtask

// One pass over all vectors, random gaps and wb_ready when backpressure is set
task automatic run_pass(input logic backpressure);
    int       idx_q[$];
    int       cycle_q[$];
    int       sent;
    int       received;
    int       cycle;
    int       idx;
    int       req_cycle;
    logic     gap_a;
    logic     gap_b;
    logic     req_fire;
    logic     wb_fire;
    reg_idx_t got_rd;
    logic     got_we;
    word_t    got_data;
    logic     got_fault;
    sent     = 0;
    received = 0;
    cycle    = 0;
    while (received < num_vectors && cycle < PASS_TIMEOUT) begin
        // Next request once the previous one has transferred
        if (!req_valid && sent < num_vectors) begin
            gap_a = 1'b0;
            gap_b = 1'b0;
            if (backpressure) begin
                gap_a = random_bit();
                gap_b = random_bit();
            end
            if (!(gap_a && gap_b)) begin
                drive_request(sent);
            end
        end
        if (backpressure) begin
            wb_ready = random_bit();
        end else begin
            wb_ready = 1'b1;
        end
        // Sample just ahead of the rising edge
        #(CLK_PERIOD / 2 - 1);
        req_fire  = req_valid && req_ready;
        wb_fire   = wb_valid && wb_ready;
        got_rd    = wb_rd;
        got_we    = wb_we;
        got_data  = wb_data;
        got_fault = wb_fault;
        @(posedge clk);
        cycle++;
        if (wb_fire) begin
            if (idx_q.size() == 0) begin
                error_count++;
                $display("A response arrived with no request outstanding");
            end else begin
                idx       = idx_q.pop_front();
                req_cycle = cycle_q.pop_front();
                check_response(idx, got_rd, got_we, got_data, got_fault);
                // Two edges from request to writeback with no stalls
                if (!backpressure) begin
                    check_value($sformatf("latency (vector %0d)", idx),
                                32'(cycle - req_cycle), 32'd2);
                end
                received++;
            end
        end
        if (req_fire) begin
            idx_q.push_back(sent);
            cycle_q.push_back(cycle);
            sent++;
        end
        @(negedge clk);
        if (req_fire) begin
            req_valid = 1'b0;
        end
    end
    if (received < num_vectors) begin
        error_count++;
        $display("Timed out with %0d of %0d responses received", received, num_vectors);
    end
    req_valid = 1'b0;
endtask

initial begin
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req_op      = MEM_OP_NOP;
    req_size    = MEM_SIZE_WORD;
    req_signed  = 1'b0;
    req_base    = '0;
    req_offset  = '0;
    req_wdata   = '0;
    req_rd      = '0;
    wb_ready    = 1'b0;
    error_count = 0;
    check_count = 0;
    lfsr_state  = LFSR_SEED;
    load_golden();
    apply_reset();
    if (num_vectors > 0) begin
        run_pass(1'b1);
        run_pass(1'b0);
        // No stray responses once both passes have drained
        repeat (IDLE_CYCLES) begin
            #(CLK_PERIOD / 2 - 1);
            check_value("wb_valid (idle)", 32'(wb_valid), 32'h0);
            @(negedge clk);
        end
    end else begin
        error_count++;
        $display("The golden file holds no requests");
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
        $display(">>> PASS");
    end else begin
        $display(">>> FAIL");
    end
    $finish;
end

endmodule : tb_lsu_top

// ==== lsu_golden.txt ====
# op size signed base offset wdata rd exp_data exp_fault, all hex
# op 1 load 2 store, size 0 byte 1 halfword 2 word
2 2 0 00000100 00000000 12345678 00 00000000 0
1 2 0 00000100 00000000 00000000 05 12345678 0
2 2 0 00000100 00000004 a5a5a5a5 00 00000000 0
2 0 0 00000104 00000001 0000003c 00 00000000 0
2 1 0 00000104 00000002 cafebeef 00 00000000 0
1 2 0 00000100 00000004 00000000 06 beef3ca5 0
2 0 0 00000100 00000003 123456f0 00 00000000 0
1 2 0 00000100 00000000 00000000 07 f0345678 0
1 0 1 00000104 00000000 00000000 08 ffffffa5 0
1 0 0 00000104 00000000 00000000 09 000000a5 0
1 0 1 00000104 00000001 00000000 0a 0000003c 0
1 0 0 00000104 00000001 00000000 0b 0000003c 0
1 0 1 00000104 00000002 00000000 0c ffffffef 0
1 0 0 00000104 00000002 00000000 0d 000000ef 0
1 0 1 00000104 00000003 00000000 0e ffffffbe 0
1 0 0 00000104 00000003 00000000 0f 000000be 0
1 1 1 00000104 00000000 00000000 10 00003ca5 0
1 1 0 00000104 00000000 00000000 11 00003ca5 0
1 1 1 00000104 00000002 00000000 12 ffffbeef 0
1 1 0 00000104 00000002 00000000 13 0000beef 0
1 1 1 00000100 00000002 00000000 14 fffff034 0
2 2 0 00000200 00000000 80ff7f01 00 00000000 0
1 0 1 00000200 00000001 00000000 15 0000007f 0
1 0 1 00000200 00000003 00000000 16 ffffff80 0
1 1 1 00000200 00000002 00000000 17 ffff80ff 0
1 1 0 00000200 00000000 00000000 18 00007f01 0
2 2 0 00000100 00000001 deadbeef 00 00000000 1
2 1 0 00000100 00000003 00001111 00 00000000 1
1 2 0 00000100 00000002 00000000 19 00000000 1
1 1 0 00000104 00000001 00000000 1a 00000000 1
1 2 0 00000100 00000000 00000000 1b f0345678 0
1 2 0 00000110 fffffff4 00000000 1c beef3ca5 0

// ==== flist.f ====
lsu_isa_pkg.sv
lsu_pipe_pkg.sv
lsu_stage_mem1.sv
lsu_pipe_reg.sv
lsu_data_ram.sv
lsu_stage_mem2.sv
lsu_top.sv
tb_lsu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)
PASS_MSG  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
